// ==== design/nes_consts.svh ====
/*
 * Console I/O constants
 * Frame and port sizes, ROM address layout and iNES header magic
 */
`ifndef NES_CONSTS_SVH
`define NES_CONSTS_SVH

`define PAD_FRAME_BITS 24      // Bits per console port frame
`define PAD_PORTS      2
`define HOST_PADS      4

`define ROM_ADDR_W     22
`define CHR_BASE_ADDR  22'h200000  // CHR lives in the upper half
`define PRG_PAGE_SHIFT 14      // 16 KB pages
`define CHR_PAGE_SHIFT 13      // 8 KB pages

`define INES_MAGIC0    8'h4E
`define INES_MAGIC1    8'h45
`define INES_MAGIC2    8'h53
`define INES_MAGIC3    8'h1A

`define TAP_SIG_PORT0  8'h08
`define TAP_SIG_PORT1  8'h04

`endif

// ==== design/nes_io_pkg.sv ====
/*
 * Shared types for the cartridge loader and the controller ports
 */
`default_nettype none

`include "nes_consts.svh"

package nes_io_pkg;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_FAIL
	} load_state_e;

	// Joystick bits as the host delivers them
	typedef struct packed {
		logic start;
		logic select;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;   // Bit 0
	} host_pad_t;

	// Console shift order, a goes out first
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic b;
		logic a;       // Bit 0
	} nes_pad_t;

	typedef logic [15:0][7:0] ines_header_t;  // Index is the header byte number

	typedef struct packed {
		logic [7:0] submapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic                   strobe;
		logic [`ROM_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} rom_write_t;

endpackage

`default_nettype wire

// ==== design/ines_header_decode.sv ====
/*
 * iNES header decoder
 * Checks the magic and trainer bit, tells NES 2.0 from dirty iNES 1.0
 * headers and builds the mapper flags
 */
`default_nettype none

`include "nes_consts.svh"

module ines_header_decode (
	input  nes_io_pkg::ines_header_t  header,
	input  logic                      invert_mirroring,
	output logic                      header_valid,
	output logic [7:0]                prg_pages,
	output logic [7:0]                chr_pages,
	output nes_io_pkg::mapper_flags_t flags
);

	logic magic_ok;
	logic is_nes20;
	logic is_dirty;

	// Smallest n with pages <= 2**n, saturates at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if (pages <= 8'(1 << n))
				code = 3'(n);
		end
		return code;
	endfunction

	assign magic_ok = (header[0] == `INES_MAGIC0) && (header[1] == `INES_MAGIC1) &&
		(header[2] == `INES_MAGIC2) && (header[3] == `INES_MAGIC3);
	assign header_valid = magic_ok && !header[6][2];  // Trainers not supported

	assign is_nes20 = (header[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && ((header[9][7:1] != 7'd0) || (|header[15:10]));

	assign prg_pages = header[4];
	assign chr_pages = header[5];

	always_comb begin
		flags.mapper      = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
		flags.prg_size    = size_code(prg_pages);
		flags.chr_size    = size_code(chr_pages);
		flags.mirroring   = header[6][0] ^ invert_mirroring;
		flags.chr_ram     = (chr_pages == 8'd0);
		flags.four_screen = header[6][3];
		flags.submapper   = is_nes20 ? header[8] : 8'h00;
	end

endmodule

`default_nettype wire

// ==== design/rom_loader.sv ====
/*
 * Cartridge ROM loader
 * Captures the iNES header from the byte stream, then writes PRG from
 * address 0 and CHR from the CHR base, and latches the mapper flags
 */
`default_nettype none

`include "nes_consts.svh"

module rom_loader (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [7:0]                rom_byte,
	input  logic                      rom_strobe,
	input  logic                      invert_mirroring,
	output nes_io_pkg::rom_write_t    rom_write,
	output nes_io_pkg::mapper_flags_t mapper_flags,
	output logic                      load_done,
	output logic                      load_error
);

	nes_io_pkg::load_state_e   state;
	nes_io_pkg::ines_header_t  header;
	nes_io_pkg::mapper_flags_t flags;
	logic [3:0]                hdr_count;
	logic [`ROM_ADDR_W-1:0]    bytes_left;
	logic [`ROM_ADDR_W-1:0]    write_addr;
	logic                      header_valid;
	logic [7:0]                prg_pages;
	logic [7:0]                chr_pages;
	logic                      payload_state;
	logic                      enter_done;

	ines_header_decode u_decode (
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.header_valid     (header_valid),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (flags)
	);

	assign payload_state = (state == nes_io_pkg::LOAD_PRG) || (state == nes_io_pkg::LOAD_CHR);

	// Write goes out in the same cycle as the byte
	assign rom_write.strobe = rom_strobe && payload_state && (bytes_left != '0);
	assign rom_write.addr   = write_addr;
	assign rom_write.data   = rom_byte;

	assign enter_done = (bytes_left == '0) && header_valid &&
		((state == nes_io_pkg::LOAD_CHR) ||
		((state == nes_io_pkg::LOAD_PRG) && (chr_pages == 8'd0)));

	always_ff @(posedge clk) begin
		if (state == nes_io_pkg::LOAD_HEADER && rom_strobe)
			header[hdr_count] <= rom_byte;
		if (enter_done)
			mapper_flags <= flags;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= nes_io_pkg::LOAD_HEADER;
			hdr_count  <= 4'd0;
			bytes_left <= '0;
			write_addr <= '0;
			load_done  <= 1'b0;
			load_error <= 1'b0;
		end else begin
			case (state)
				nes_io_pkg::LOAD_HEADER: if (rom_strobe) begin
					hdr_count <= hdr_count + 4'd1;
					if (hdr_count == 4'd15) begin
						state      <= nes_io_pkg::LOAD_PRG;
						write_addr <= '0;
						// A bad header leaves nothing to load
						bytes_left <= header_valid ?
							(`ROM_ADDR_W'(prg_pages) << `PRG_PAGE_SHIFT) : '0;
					end
				end
				nes_io_pkg::LOAD_PRG: begin
					if (bytes_left != '0) begin
						if (rom_strobe) begin
							bytes_left <= bytes_left - 1'b1;
							write_addr <= write_addr + 1'b1;
						end
					end else if (!header_valid) begin
						state <= nes_io_pkg::LOAD_FAIL;
					end else if (chr_pages == 8'd0) begin
						state <= nes_io_pkg::LOAD_DONE;  // CHR RAM cart
					end else begin
						state      <= nes_io_pkg::LOAD_CHR;
						write_addr <= `CHR_BASE_ADDR;
						bytes_left <= `ROM_ADDR_W'(chr_pages) << `CHR_PAGE_SHIFT;
					end
				end
				nes_io_pkg::LOAD_CHR: begin
					if (bytes_left != '0) begin
						if (rom_strobe) begin
							bytes_left <= bytes_left - 1'b1;
							write_addr <= write_addr + 1'b1;
						end
					end else begin
						state <= nes_io_pkg::LOAD_DONE;
					end
				end
				nes_io_pkg::LOAD_DONE: load_done <= 1'b1;
				nes_io_pkg::LOAD_FAIL: begin
					load_done  <= 1'b1;
					load_error <= 1'b1;
				end
				default: state <= nes_io_pkg::LOAD_HEADER;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/pad_frame_builder.sv ====
/*
 * Controller frame builder
 * Reorders host joystick bits for the console, applies the port swap
 * and appends the multitap pad and signature
 */
`default_nettype none

`include "nes_consts.svh"

module pad_frame_builder (
	input  logic                        reset,
	input  nes_io_pkg::host_pad_t       host_pads [`HOST_PADS],
	input  logic                        joy_swap,
	input  logic                        multitap_en,
	output logic [`PAD_FRAME_BITS-1:0]  frames [`PAD_PORTS]
);

	function automatic nes_io_pkg::nes_pad_t to_console(input nes_io_pkg::host_pad_t h);
		nes_io_pkg::nes_pad_t n;
		n.a      = h.a;
		n.b      = h.b;
		n.select = h.select;
		n.start  = h.start;
		n.up     = h.up;
		n.down   = h.down;
		n.left   = h.left;
		n.right  = h.right;
		return n;
	endfunction

	always_comb begin
		nes_io_pkg::nes_pad_t prim;
		nes_io_pkg::nes_pad_t tap_pad;
		logic [7:0]           tap_sig;
		for (int p = 0; p < `PAD_PORTS; p++) begin
			prim    = to_console(host_pads[joy_swap ? 1 - p : p]);
			tap_pad = multitap_en ? to_console(host_pads[p + `PAD_PORTS]) : '0;
			tap_sig = (p == 0) ? `TAP_SIG_PORT0 : `TAP_SIG_PORT1;
			if (!multitap_en)
				tap_sig = 8'h00;
			frames[p] = reset ? '0 : {tap_sig, tap_pad, prim};  // Pad bits leave first
		end
	end

endmodule

`default_nettype wire

// ==== design/pad_port_shifter.sv ====
/*
 * Console controller port
 * Loads a frame on strobe and shifts it out LSB first on falling port clock
 */
`default_nettype none

`include "nes_consts.svh"

module pad_port_shifter (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`PAD_FRAME_BITS-1:0] frame,
	input  logic                       pad_strobe,
	input  logic                       pad_clock,
	output logic                       pad_data
);

	logic [`PAD_FRAME_BITS-1:0] shift_reg;
	logic                       clock_prev;

	always_ff @(posedge clk) begin
		if (reset) begin
			shift_reg  <= '0;
			clock_prev <= 1'b0;
		end else begin
			if (pad_strobe)
				shift_reg <= frame;
			if (!pad_clock && clock_prev)  // Falling edge beats the load
				shift_reg <= {1'b0, shift_reg[`PAD_FRAME_BITS-1:1]};
			clock_prev <= pad_clock;
		end
	end

	assign pad_data = shift_reg[0];

endmodule

`default_nettype wire

// ==== design/nes_cart_io_top.sv ====
/*
 * Cartridge and controller I/O top level
 * ROM loader plus the frame builder feeding one shifter per console port
 */
`default_nettype none

`include "nes_consts.svh"

module nes_cart_io_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [7:0]                rom_byte,
	input  logic                      rom_strobe,
	input  logic                      invert_mirroring,
	output nes_io_pkg::rom_write_t    rom_write,
	output nes_io_pkg::mapper_flags_t mapper_flags,
	output logic                      load_done,
	output logic                      load_error,
	input  nes_io_pkg::host_pad_t     host_pads [`HOST_PADS],
	input  logic                      joy_swap,
	input  logic                      multitap_en,
	input  logic                      pad_strobe,
	input  logic [`PAD_PORTS-1:0]     pad_clock,
	output logic [`PAD_PORTS-1:0]     pad_data
);

	logic [`PAD_FRAME_BITS-1:0] frames [`PAD_PORTS];

	rom_loader u_loader (
		.clk              (clk),
		.reset            (reset),
		.rom_byte         (rom_byte),
		.rom_strobe       (rom_strobe),
		.invert_mirroring (invert_mirroring),
		.rom_write        (rom_write),
		.mapper_flags     (mapper_flags),
		.load_done        (load_done),
		.load_error       (load_error)
	);

	pad_frame_builder u_frames (
		.reset       (reset),
		.host_pads   (host_pads),
		.joy_swap    (joy_swap),
		.multitap_en (multitap_en),
		.frames      (frames)
	);

	for (genvar i = 0; i < `PAD_PORTS; i++) begin : g_port
		pad_port_shifter u_shifter (
			.clk        (clk),
			.reset      (reset),
			.frame      (frames[i]),
			.pad_strobe (pad_strobe),
			.pad_clock  (pad_clock[i]),
			.pad_data   (pad_data[i])
		);
	end

endmodule

`default_nettype wire

// ==== dv/nes_cart_io_tb.sv ====
/*
 * Testbench for the cartridge and controller I/O top level
 * Directed loader and pad port tests against expected writes, flags and bits
 */
`default_nettype none

`include "nes_consts.svh"

module nes_cart_io_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLE_LIMIT = 60000;  // Largest test moves about 41000 bytes

	logic                       clk = 1'b0;
	logic                       reset;
	logic [7:0]                 rom_byte;
	logic                       rom_strobe;
	logic                       invert_mirroring;
	nes_io_pkg::rom_write_t     rom_write;
	nes_io_pkg::mapper_flags_t  mapper_flags;
	logic                       load_done;
	logic                       load_error;
	nes_io_pkg::host_pad_t      host_pads [`HOST_PADS];
	logic                       joy_swap;
	logic                       multitap_en;
	logic                       pad_strobe;
	logic [`PAD_PORTS-1:0]      pad_clock;
	logic [`PAD_PORTS-1:0]      pad_data;

	integer seed = 90857;
	int     cycle_count = 0;
	int     test_errors = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	string  cur_test = "init";

	nes_cart_io_top dut0 (.*);

	always #10 clk = ~clk;

	// Per-test cycle budget
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timed out: test %s ran past %0d cycles", cur_test, CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
		cycle_count = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, test_errors);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		reset = 1'b1;
		rom_strobe = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	task automatic check_write(input nes_io_pkg::rom_write_t expected,
			input nes_io_pkg::rom_write_t actual);
		logic bad;
		bad = expected.strobe ? (actual !== expected) : (actual.strobe !== 1'b0);  // No write
		if (bad) begin
			$display("FAIL %s write: expected %h, actual %h", cur_test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_flags(input nes_io_pkg::mapper_flags_t expected,
			input nes_io_pkg::mapper_flags_t actual);
		if (actual !== expected) begin
			$display("FAIL %s flags: expected %h, actual %h", cur_test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s %s: expected %b, actual %b", cur_test, what, expected, actual);
			test_errors++;
		end
	endtask

	function automatic nes_io_pkg::ines_header_t make_header(input logic [7:0] prg,
			input logic [7:0] chr, input logic [7:0] b6, input logic [7:0] b7,
			input logic [7:0] b8);
		nes_io_pkg::ines_header_t h;
		h = '0;
		h[0] = `INES_MAGIC0;
		h[1] = `INES_MAGIC1;
		h[2] = `INES_MAGIC2;
		h[3] = `INES_MAGIC3;
		h[4] = prg;
		h[5] = chr;
		h[6] = b6;
		h[7] = b7;
		h[8] = b8;
		return h;
	endfunction

	// Byte is taken on the next rising edge, write checked before it
	task automatic send_byte(input logic [7:0] data, input logic exp_strobe,
			input logic [`ROM_ADDR_W-1:0] exp_addr);
		nes_io_pkg::rom_write_t expected;
		@(posedge clk);
		#2;
		rom_strobe = 1'b1;
		rom_byte = data;
		@(negedge clk);
		expected.strobe = exp_strobe;
		expected.addr = exp_addr;
		expected.data = data;
		check_write(expected, rom_write);
	endtask

	task automatic end_bytes();
		@(posedge clk);
		#2;
		rom_strobe = 1'b0;
	endtask

	task automatic send_header(input nes_io_pkg::ines_header_t h);
		for (int i = 0; i < 16; i++)
			send_byte(h[i], 1'b0, '0);
	endtask

	task automatic send_payload(input int count, input logic [`ROM_ADDR_W-1:0] base);
		logic [7:0] data;
		for (int i = 0; i < count; i++) begin
			data = 8'($random(seed));
			send_byte(data, 1'b1, base + `ROM_ADDR_W'(i));
		end
		end_bytes();  // Leaves one idle cycle
	endtask

	// Entered just after the edge that took the last byte
	task automatic wait_done();
		int n;
		n = 0;
		while (load_done !== 1'b1 && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (load_done !== 1'b1) begin
			$display("Test %s: load_done never rose after the last byte", cur_test);
			test_errors++;
		end else if (n != 3) begin
			$display("Test %s: load_done rose after %0d edges instead of 2", cur_test, n - 1);
			test_errors++;
		end
	endtask

	function automatic logic [7:0] console_order(input nes_io_pkg::host_pad_t h);
		return {h.right, h.left, h.down, h.up, h.start, h.select, h.b, h.a};
	endfunction

	task automatic randomize_pads();
		logic [7:0] r;
		@(posedge clk);
		#2;
		for (int i = 0; i < `HOST_PADS; i++) begin
			r = 8'($random(seed));
			host_pads[i] = r;
		end
	endtask

	task automatic strobe_pads();
		@(posedge clk);
		#2;
		pad_strobe = 1'b1;
		@(posedge clk);
		#2;
		pad_strobe = 1'b0;
	endtask

	task automatic shift_port(input int p, output logic bit_out);
		@(posedge clk);
		#2;
		pad_clock[p] = 1'b0;
		@(posedge clk);  // Falling port clock seen here
		#2;
		pad_clock[p] = 1'b1;
		@(negedge clk);
		bit_out = pad_data[p];
	endtask

	task automatic read_port(input int p, input logic [`PAD_FRAME_BITS-1:0] frame);
		logic b;
		strobe_pads();
		@(negedge clk);
		check_bit($sformatf("port %0d bit 0", p), frame[0], pad_data[p]);
		for (int i = 1; i < `PAD_FRAME_BITS; i++) begin
			shift_port(p, b);
			check_bit($sformatf("port %0d bit %0d", p, i), frame[i], b);
		end
	endtask

	task automatic test_reset();
		nes_io_pkg::ines_header_t h;
		start_test("reset");
		apply_reset();
		@(negedge clk);
		check_bit("load_done", 1'b0, load_done);
		check_bit("load_error", 1'b0, load_error);
		check_bit("write strobe", 1'b0, rom_write.strobe);
		check_bit("pad_data 0", 1'b0, pad_data[0]);
		check_bit("pad_data 1", 1'b0, pad_data[1]);
		h = make_header(8'd1, 8'd0, 8'h00, 8'h00, 8'h00);
		for (int i = 0; i < 4; i++)
			send_byte(h[i], 1'b0, '0);
		end_bytes();
		finish_test();
	endtask

	task automatic test_small_rom();
		nes_io_pkg::mapper_flags_t f;
		start_test("small_rom");
		apply_reset();
		send_header(make_header(8'd1, 8'd0, 8'h10, 8'h00, 8'h00));
		send_payload(1 << `PRG_PAGE_SHIFT, '0);
		wait_done();
		check_bit("load_error", 1'b0, load_error);
		f = '0;
		f.mapper = 8'h01;
		f.chr_ram = 1'b1;
		check_flags(f, mapper_flags);
		finish_test();
	endtask

	task automatic test_nes20_rom();
		nes_io_pkg::mapper_flags_t f;
		start_test("nes20_rom");
		apply_reset();
		invert_mirroring = 1'b1;
		send_header(make_header(8'd2, 8'd1, 8'h21, 8'h48, 8'h35));
		send_payload(2 << `PRG_PAGE_SHIFT, '0);
		send_payload(1 << `CHR_PAGE_SHIFT, `CHR_BASE_ADDR);
		wait_done();
		check_bit("load_error", 1'b0, load_error);
		f = '0;
		f.mapper = 8'h42;
		f.prg_size = 3'd1;
		f.submapper = 8'h35;  // Mirroring bit cancelled by the invert
		check_flags(f, mapper_flags);
		invert_mirroring = 1'b0;
		finish_test();
	endtask

	task automatic test_dirty_header();
		nes_io_pkg::ines_header_t h;
		nes_io_pkg::mapper_flags_t f;
		start_test("dirty_header");
		apply_reset();
		h = make_header(8'd1, 8'd0, 8'h39, 8'h50, 8'h00);
		h[12] = 8'h01;
		send_header(h);
		send_payload(1 << `PRG_PAGE_SHIFT, '0);
		wait_done();
		check_bit("load_error", 1'b0, load_error);
		f = '0;
		f.mapper = 8'h03;
		f.chr_ram = 1'b1;
		f.mirroring = 1'b1;
		f.four_screen = 1'b1;
		check_flags(f, mapper_flags);
		finish_test();
	endtask

	task automatic test_bad_magic();
		nes_io_pkg::ines_header_t h;
		start_test("bad_magic");
		apply_reset();
		h = make_header(8'd1, 8'd0, 8'h00, 8'h00, 8'h00);
		h[3] = 8'h1B;
		send_header(h);
		end_bytes();
		wait_done();
		check_bit("load_error", 1'b1, load_error);
		for (int i = 0; i < 4; i++)
			send_byte(8'($random(seed)), 1'b0, '0);
		end_bytes();
		check_bit("load_done held", 1'b1, load_done);
		finish_test();
	endtask

	task automatic test_pads_basic();
		start_test("pads_basic");
		apply_reset();
		randomize_pads();
		read_port(0, {16'h0, console_order(host_pads[0])});
		read_port(1, {16'h0, console_order(host_pads[1])});
		@(posedge clk);
		#2;
		joy_swap = 1'b1;
		read_port(0, {16'h0, console_order(host_pads[1])});
		joy_swap = 1'b0;
		finish_test();
	endtask

	task automatic test_multitap();
		start_test("multitap");
		apply_reset();
		randomize_pads();
		multitap_en = 1'b1;
		read_port(0, {`TAP_SIG_PORT0, console_order(host_pads[2]), console_order(host_pads[0])});
		read_port(1, {`TAP_SIG_PORT1, console_order(host_pads[3]), console_order(host_pads[1])});
		multitap_en = 1'b0;
		finish_test();
	endtask

	initial begin
		reset = 1'b1;
		rom_byte = 8'h00;
		rom_strobe = 1'b0;
		invert_mirroring = 1'b0;
		joy_swap = 1'b0;
		multitap_en = 1'b0;
		pad_strobe = 1'b0;
		pad_clock = '1;  // Port clocks idle high
		for (int i = 0; i < `HOST_PADS; i++)
			host_pads[i] = '0;
		test_reset();
		test_small_rom();
		test_nes20_rom();
		test_dirty_header();
		test_bad_magic();
		test_pads_basic();
		test_multitap();
		$display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/nes_io_pkg.sv
design/ines_header_decode.sv
design/rom_loader.sv
design/pad_frame_builder.sv
design/pad_port_shifter.sv
design/nes_cart_io_top.sv
dv/nes_cart_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module nes_cart_io_tb \
	-f list.f -Mdir obj_dir -o nes_cart_io_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/nes_cart_io_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0
